/* aluUnit.sv */
`timescale 1ns/1ps

module aluUnit
	import rvIsaPkg::*, rvCorePkg::*;
(
	input  ctrlT        ctrl,
	input  logic [31:0] pc,
	input  logic [31:0] rs1Data,
	input  logic [31:0] rs2Data,
	input  logic [31:0] imm,
	output logic [31:0] result
);

	logic [31:0] opA;
	logic [31:0] opB;
	logic [4:0]  shamt; // Low bits of operand B

	////////////////////////////////////////////////////////////
	// Operand selection
	////////////////////////////////////////////////////////////
	always_comb begin
		if (ctrl.pcOperand)
			opA = pc; // AUIPC and JAL
		else if (ctrl.setDataZero)
			opA = '0; // LUI
		else
			opA = rs1Data;
	end

	assign opB = ctrl.immSel ? imm : rs2Data;
	assign shamt = opB[4:0];

	////////////////////////////////////////////////////////////
	// Operations
	////////////////////////////////////////////////////////////
	always_comb begin
		case (ctrl.aluOp)
			ALU_ADD:  result = opA + opB;
			ALU_SUB:  result = opA - opB;
			ALU_SLL:  result = opA << shamt;
			ALU_SLT:  result = {31'b0, $signed(opA) < $signed(opB)};
			ALU_SLTU: result = {31'b0, opA < opB};
			ALU_XOR:  result = opA ^ opB;
			ALU_SRL:  result = opA >> shamt;
			ALU_SRA:  result = $unsigned($signed(opA) >>> shamt);
			ALU_OR:   result = opA | opB;
			ALU_AND:  result = opA & opB;
			default:  result = '0;
		endcase
	end

endmodule

/* controlUnit.sv */
`timescale 1ns/1ps

module controlUnit
	import rvIsaPkg::*, rvCorePkg::*;
(
	input  logic [31:0] instr,
	output ctrlT        ctrl
);

	opcodeT      opcode;
	logic [2:0]  funct3;
	logic [6:0]  funct7;
	aluOpT       funcAluOp; // Op picked by funct fields

	assign opcode = opcodeT'(instr[6:0]);
	assign funct3 = instr[14:12];
	assign funct7 = instr[31:25];

	////////////////////////////////////////////////////////////
	// ALU op from funct3 and funct7
	////////////////////////////////////////////////////////////
	always_comb begin
		case (funct3)
			3'b000: funcAluOp = (opcode == OPC_OP && funct7 == 7'b0100000) ? ALU_SUB : ALU_ADD;
			3'b001: funcAluOp = ALU_SLL;
			3'b010: funcAluOp = ALU_SLT;
			3'b011: funcAluOp = ALU_SLTU;
			3'b100: funcAluOp = ALU_XOR;
			3'b101: funcAluOp = (funct7 == 7'b0100000) ? ALU_SRA : ALU_SRL; // Also SRAI
			3'b110: funcAluOp = ALU_OR;
			default: funcAluOp = ALU_AND;
		endcase
	end

	////////////////////////////////////////////////////////////
	// Main decode
	////////////////////////////////////////////////////////////
	always_comb begin
		ctrl = '0; // Unknown opcode retires as no-op
		ctrl.aluOp = ALU_ADD;
		ctrl.immType = IMM_ISEXT;
		ctrl.memType = memWidthT'(funct3);
		ctrl.branchCond = branchCondT'(funct3);
		case (opcode)
			OPC_LUI: begin
				ctrl.setDataZero = 1'b1; // 0 + imm
				ctrl.immSel = 1'b1;
				ctrl.immType = IMM_U;
				ctrl.regWriteEnable = 1'b1;
			end
			OPC_AUIPC: begin
				ctrl.pcOperand = 1'b1; // pc + imm
				ctrl.immSel = 1'b1;
				ctrl.immType = IMM_U;
				ctrl.regWriteEnable = 1'b1;
			end
			OPC_JAL: begin
				ctrl.pcOperand = 1'b1;
				ctrl.immSel = 1'b1;
				ctrl.immType = IMM_J;
				ctrl.regWriteEnable = 1'b1;
				ctrl.addConstant4 = 1'b1; // Link
				ctrl.jump = 1'b1;
				ctrl.jumpAL = 1'b1;
			end
			OPC_JALR: begin
				ctrl.immSel = 1'b1; // Target rs1 + imm
				ctrl.regWriteEnable = 1'b1;
				ctrl.addConstant4 = 1'b1;
				ctrl.jump = 1'b1;
			end
			OPC_BRANCH: begin
				ctrl.branch = 1'b1;
				ctrl.immSel = 1'b1;
				ctrl.immType = IMM_B;
			end
			OPC_LOAD: begin
				ctrl.immSel = 1'b1; // Address rs1 + imm
				ctrl.regWriteEnable = 1'b1;
				ctrl.memRead = 1'b1;
			end
			OPC_STORE: begin
				ctrl.immSel = 1'b1;
				ctrl.immType = IMM_S;
				ctrl.memWrite = 1'b1;
			end
			OPC_OPIMM: begin
				ctrl.immSel = 1'b1;
				ctrl.regWriteEnable = 1'b1;
				ctrl.aluOp = funcAluOp;
			end
			OPC_OP: begin
				ctrl.regWriteEnable = 1'b1;
				ctrl.aluOp = funcAluOp;
			end
			default: ;
		endcase
	end

	// A single access per instruction on the data port
	assert property (@(instr) !(ctrl.memRead && ctrl.memWrite))
		else $error("controlUnit: memRead and memWrite both set");

endmodule

/* fetchUnit.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module fetchUnit
	import rvIsaPkg::*, rvCorePkg::*;
(
	input  logic        clk,
	input  logic        arstN,
	input  ctrlT        ctrl,
	input  logic [31:0] rs1Data,
	input  logic [31:0] rs2Data,
	input  logic [31:0] imm,
	input  logic [31:0] aluResult,
	output logic [31:0] pc
);

	logic        condMet;
	logic        taken;
	logic [31:0] nextPc;

	////////////////////////////////////////////////////////////
	// Branch resolution
	////////////////////////////////////////////////////////////
	always_comb begin
		case (ctrl.branchCond)
			BR_EQ:   condMet = rs1Data == rs2Data;
			BR_NE:   condMet = rs1Data != rs2Data;
			BR_LT:   condMet = $signed(rs1Data) < $signed(rs2Data);
			BR_GE:   condMet = $signed(rs1Data) >= $signed(rs2Data);
			BR_LTU:  condMet = rs1Data < rs2Data;
			BR_GEU:  condMet = rs1Data >= rs2Data;
			default: condMet = 1'b0; // Reserved funct3
		endcase
	end

	assign taken = ctrl.branch && condMet;

	always_comb begin
		if (ctrl.jump && !ctrl.jumpAL)
			nextPc = {aluResult[31:1], 1'b0}; // JALR
		else if ((ctrl.jump && ctrl.jumpAL) || taken)
			nextPc = pc + imm; // JAL or taken branch
		else
			nextPc = pc + 32'd4;
	end

	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN)
			pc <= `RESET_PC;
		else
			pc <= nextPc;
	end

	// Program stays word aligned
	assert property (@(posedge clk) disable iff (!arstN) pc[1:0] == 2'b00)
		else $error("fetchUnit: pc %h not word aligned", pc);

endmodule

/* immGen.sv */
`timescale 1ns/1ps

module immGen
	import rvIsaPkg::*;
(
	input  logic [31:0] instr,
	input  immTypeT     immType,
	output logic [31:0] imm
);

	logic sign; // Instruction bit 31

	assign sign = instr[31];

	////////////////////////////////////////////////////////////
	// Field reassembly per format
	////////////////////////////////////////////////////////////
	always_comb begin
		case (immType)
			IMM_ISEXT: imm = {{20{sign}}, instr[31:20]};
			IMM_IZEXT: imm = {20'b0, instr[31:20]};
			IMM_S:     imm = {{20{sign}}, instr[31:25], instr[11:7]};
			IMM_B:     imm = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
			IMM_U:     imm = {instr[31:12], 12'b0};
			IMM_J:     imm = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};
			default:   imm = '0; // Unused encodings
		endcase
	end

endmodule

/* lsuAlign.sv */
`timescale 1ns/1ps

module lsuAlign
	import rvIsaPkg::*, rvCorePkg::*;
(
	input  ctrlT        ctrl,
	input  logic [31:0] addr,
	input  logic [31:0] storeData,
	input  logic [31:0] dmemRdata,
	input  logic [31:0] pc,
	input  logic [31:0] aluResult,
	output dmemReqT     dmemReq,
	output logic [31:0] wbData
);

	logic [4:0]  laneShift; // Byte offset in bits
	logic [3:0]  widthMask;
	logic [31:0] laneData;
	logic [31:0] loadData;

	assign laneShift = {addr[1:0], 3'b000};

	////////////////////////////////////////////////////////////
	// Request side
	////////////////////////////////////////////////////////////
	always_comb begin
		case (ctrl.memType)
			MEM_BYTE, MEM_BYTEU: widthMask = 4'b0001;
			MEM_HALF, MEM_HALFU: widthMask = 4'b0011;
			default:             widthMask = 4'b1111; // Word
		endcase
	end

	assign dmemReq.addr   = {addr[31:2], 2'b00};
	assign dmemReq.wdata  = storeData << laneShift;
	assign dmemReq.byteEn = (ctrl.memRead || ctrl.memWrite) ? (widthMask << addr[1:0]) : 4'b0000;
	assign dmemReq.read   = ctrl.memRead;
	assign dmemReq.write  = ctrl.memWrite;

	////////////////////////////////////////////////////////////
	// Load extraction and writeback
	////////////////////////////////////////////////////////////
	assign laneData = dmemRdata >> laneShift; // Addressed lane to bit 0

	always_comb begin
		case (ctrl.memType)
			MEM_BYTE:  loadData = {{24{laneData[7]}}, laneData[7:0]};
			MEM_HALF:  loadData = {{16{laneData[15]}}, laneData[15:0]};
			MEM_BYTEU: loadData = {24'b0, laneData[7:0]};
			MEM_HALFU: loadData = {16'b0, laneData[15:0]};
			default:   loadData = laneData;
		endcase
	end

	always_comb begin
		if (ctrl.addConstant4)
			wbData = pc + 32'd4; // Link address
		else if (ctrl.memRead)
			wbData = loadData;
		else
			wbData = aluResult;
	end

endmodule

/* project.f */
+incdir+.
rvIsaPkg.sv
rvCorePkg.sv
controlUnit.sv
immGen.sv
aluUnit.sv
regFile.sv
lsuAlign.sv
fetchUnit.sv
rvCore.sv
tb_rvCore.sv

/* regFile.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module regFile (
	input  logic        clk,
	input  logic        arstN,
	input  logic [4:0]  rs1,
	input  logic [4:0]  rs2,
	input  logic [4:0]  rd,
	input  logic        we,
	input  logic [31:0] wdata,
	output logic [31:0] rs1Data,
	output logic [31:0] rs2Data
);

	logic [31:0] regs [`REG_COUNT];

	////////////////////////////////////////////////////////////
	// Write port
	////////////////////////////////////////////////////////////
	always_ff @(posedge clk or negedge arstN) begin
		if (!arstN) begin
			for (int i = 0; i < `REG_COUNT; i++)
				regs[i] <= '0;
		end else if (we && rd != 5'd0) begin // x0 stays zero
			regs[rd] <= wdata;
		end
	end

	// Read ports see the old value on a same-cycle write
	assign rs1Data = regs[rs1];
	assign rs2Data = regs[rs2];

	// x0 holds zero across every write
	assert property (@(posedge clk) disable iff (!arstN) regs[0] == 32'd0)
		else $error("regFile: x0 is not zero");

endmodule

/* run.sh */
#!/bin/bash
# Build and run the RV32I core testbench with Verilator

cd "$(dirname "$0")" || exit 1
rm -f sim.log

verilator --binary --timing --assert -f project.f --top-module tb_rvCore -o simv \
	|| { echo "Compile error"; exit 1; }

./obj_dir/simv > sim.log 2>&1 || echo "Simulator returned an error status"
cat sim.log

! grep -q "Test FAILED" sim.log && grep -q "Test OK" sim.log || exit 1
exit 0

/* rvCore.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module rvCore
	import rvCorePkg::*;
(
	input  logic        clk,
	input  logic        arstN,
	output logic [31:0] imemAddr,
	input  logic [31:0] imemData,
	output dmemReqT     dmemReq,
	input  logic [31:0] dmemRdata,
	output retireT      retire
);

	logic [31:0] instr;
	ctrlT        ctrl;
	logic [31:0] imm;
	logic [31:0] rs1Data;
	logic [31:0] rs2Data;
	logic [31:0] aluResult;
	logic [31:0] wbData;
	logic [31:0] pc;

	////////////////////////////////////////////////////////////
	// Fetch and decode
	////////////////////////////////////////////////////////////
	assign imemAddr = pc;
	assign instr = arstN ? imemData : 32'h0000_0013; // NOP held in reset

	controlUnit uControl (.instr(instr), .ctrl(ctrl));

	immGen uImm (.instr(instr), .immType(ctrl.immType), .imm(imm));

	regFile uRegs (
		.clk(clk), .arstN(arstN),
		.rs1(instr[19:15]), .rs2(instr[24:20]), .rd(instr[11:7]),
		.we(ctrl.regWriteEnable), .wdata(wbData),
		.rs1Data(rs1Data), .rs2Data(rs2Data)
	);

	////////////////////////////////////////////////////////////
	// Execute, memory, next pc
	////////////////////////////////////////////////////////////
	aluUnit uAlu (
		.ctrl(ctrl), .pc(pc), .rs1Data(rs1Data), .rs2Data(rs2Data),
		.imm(imm), .result(aluResult)
	);

	lsuAlign uLsu (
		.ctrl(ctrl), .addr(aluResult), .storeData(rs2Data), .dmemRdata(dmemRdata),
		.pc(pc), .aluResult(aluResult), .dmemReq(dmemReq), .wbData(wbData)
	);

	fetchUnit uFetch (
		.clk(clk), .arstN(arstN), .ctrl(ctrl), .rs1Data(rs1Data), .rs2Data(rs2Data),
		.imm(imm), .aluResult(aluResult), .pc(pc)
	);

	// Trace of the instruction committing at the next edge
	assign retire.valid   = arstN && `RV_TRACE_EN;
	assign retire.pc      = pc;
	assign retire.instr   = instr;
	assign retire.rdWrite = ctrl.regWriteEnable;
	assign retire.rd      = instr[11:7];
	assign retire.rdData  = wbData;

endmodule

/* rvCorePkg.sv */
package rvCorePkg;

	import rvIsaPkg::*;

	////////////////////////////////////////////////////////////
	// Decoded control bundle
	////////////////////////////////////////////////////////////
	typedef struct packed {
		aluOpT      aluOp;
		logic       immSel;         // ALU operand B is imm
		immTypeT    immType;
		logic       setDataZero;    // ALU operand A forced to 0
		logic       regWriteEnable;
		logic       memRead;
		logic       memWrite;
		logic       branch;
		logic       pcOperand;      // ALU operand A is pc
		logic       jump;
		logic       jumpAL;         // JAL as opposed to JALR
		logic       addConstant4;   // Link value pc + 4
		memWidthT   memType;
		branchCondT branchCond;
	} ctrlT;

	typedef struct packed {
		logic [31:0] addr;   // Word aligned
		logic [31:0] wdata;  // Lane shifted
		logic [3:0]  byteEn;
		logic        read;
		logic        write;
	} dmemReqT;

	typedef struct packed {
		logic        valid;
		logic [31:0] pc;
		logic [31:0] instr;
		logic        rdWrite;
		logic [4:0]  rd;
		logic [31:0] rdData;
	} retireT;

endpackage

/* rvIsaPkg.sv */
package rvIsaPkg;

	////////////////////////////////////////////////////////////
	// Base opcodes handled by the core
	////////////////////////////////////////////////////////////
	typedef enum logic [6:0] {
		OPC_LUI    = 7'b0110111,
		OPC_AUIPC  = 7'b0010111,
		OPC_JAL    = 7'b1101111,
		OPC_JALR   = 7'b1100111,
		OPC_BRANCH = 7'b1100011,
		OPC_LOAD   = 7'b0000011,
		OPC_STORE  = 7'b0100011,
		OPC_OPIMM  = 7'b0010011,
		OPC_OP     = 7'b0110011
	} opcodeT;

	typedef enum logic [3:0] {
		ALU_ADD  = 4'd0,
		ALU_SUB  = 4'd1,
		ALU_SLL  = 4'd2,
		ALU_SLT  = 4'd3,
		ALU_SLTU = 4'd4,
		ALU_XOR  = 4'd5,
		ALU_SRL  = 4'd6,
		ALU_SRA  = 4'd7,
		ALU_OR   = 4'd8,
		ALU_AND  = 4'd9
	} aluOpT;

	typedef enum logic [2:0] {
		IMM_ISEXT = 3'd0, // I-type sign extended
		IMM_IZEXT = 3'd1, // I-type zero extended
		IMM_S     = 3'd2,
		IMM_B     = 3'd3,
		IMM_U     = 3'd4,
		IMM_J     = 3'd5
	} immTypeT;

	// Encodings match load/store funct3
	typedef enum logic [2:0] {
		MEM_BYTE  = 3'b000,
		MEM_HALF  = 3'b001,
		MEM_WORD  = 3'b010,
		MEM_BYTEU = 3'b100,
		MEM_HALFU = 3'b101
	} memWidthT;

	// Encodings match branch funct3
	typedef enum logic [2:0] {
		BR_EQ  = 3'b000,
		BR_NE  = 3'b001,
		BR_LT  = 3'b100,
		BR_GE  = 3'b101,
		BR_LTU = 3'b110,
		BR_GEU = 3'b111
	} branchCondT;

endpackage

/* rv_config.svh */
`ifndef RV_CONFIG_SVH
`define RV_CONFIG_SVH

////////////////////////////////////////////////////////////
// Core build options
////////////////////////////////////////////////////////////

// First fetch address after reset
`define RESET_PC 32'h0000_0000

// Architectural integer registers
`define REG_COUNT 32

// Drive the retire port valid bit
`define RV_TRACE_EN 1'b1

`endif

/* tb_rvCore.sv */
`timescale 1ns/1ps
`include "rv_config.svh"

module tb_rvCore
	import rvCorePkg::*;
;

	localparam int CLK_PERIOD = 40;
	localparam logic [31:0] BASE = `RESET_PC;

	// One program step with its expected results
	typedef struct packed {
		logic [31:0] instr;
		logic [31:0] pc;
		logic        rdWrite;
		logic [4:0]  rd;
		logic [31:0] rdData;
		logic        memRead;
		logic        memWrite;
		logic [31:0] addr;     // Byte address before alignment
		logic [31:0] wdata;    // Lane shifted
		logic [3:0]  byteEn;
	} rowT;

	logic        clk;
	logic        arstN;
	logic [31:0] imemAddr;
	logic [31:0] imemData;
	dmemReqT     dmemReq;
	logic [31:0] dmemRdata;
	retireT      retire;

	logic [31:0] rom [64];
	logic [31:0] ram [64];
	rowT         prog [$];

	rvCore dut_i (
		.clk(clk), .arstN(arstN), .imemAddr(imemAddr), .imemData(imemData),
		.dmemReq(dmemReq), .dmemRdata(dmemRdata), .retire(retire)
	);

	always #(CLK_PERIOD / 2) clk = ~clk;

	////////////////////////////////////////////////////////////
	// Memory models
	////////////////////////////////////////////////////////////
	assign imemData = rom[imemAddr[7:2]];  // Combinational fetch
	assign dmemRdata = ram[dmemReq.addr[7:2]];

	always @(posedge clk) begin
		if (arstN && dmemReq.write) begin
			for (int b = 0; b < 4; b++)
				if (dmemReq.byteEn[b])
					ram[dmemReq.addr[7:2]][8*b +: 8] <= dmemReq.wdata[8*b +: 8];
		end
	end

	////////////////////////////////////////////////////////////
	// Instruction encoders
	////////////////////////////////////////////////////////////
	function automatic logic [31:0] encR(logic [6:0] f7, int rs2, int rs1, logic [2:0] f3, int rd);
		return {f7, 5'(rs2), 5'(rs1), f3, 5'(rd), 7'b0110011};
	endfunction

	function automatic logic [31:0] encI(int imm, int rs1, logic [2:0] f3, int rd, logic [6:0] opc);
		return {12'(imm), 5'(rs1), f3, 5'(rd), opc};
	endfunction

	function automatic logic [31:0] encS(int imm, int rs2, int rs1, logic [2:0] f3);
		logic [11:0] i;
		i = 12'(imm);
		return {i[11:5], 5'(rs2), 5'(rs1), f3, i[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] encB(int imm, int rs1, int rs2, logic [2:0] f3);
		logic [12:0] i;
		i = 13'(imm);
		return {i[12], i[10:5], 5'(rs2), 5'(rs1), f3, i[4:1], i[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] encU(logic [19:0] imm, int rd, logic [6:0] opc);
		return {imm, 5'(rd), opc};
	endfunction

	function automatic logic [31:0] encJ(int imm, int rd);
		logic [20:0] i;
		i = 21'(imm);
		return {i[20], i[10:1], i[11], i[19:12], 5'(rd), 7'b1101111};
	endfunction

	////////////////////////////////////////////////////////////
	// Table building
	////////////////////////////////////////////////////////////
	task automatic addRow(int off, logic [31:0] instr, logic wr, int rd, logic [31:0] data);
		rowT r;
		r = '0;
		r.pc = BASE + off;
		r.instr = instr;
		r.rdWrite = wr;
		r.rd = 5'(rd);
		r.rdData = data;
		prog.push_back(r);
	endtask

	task automatic addMem(logic rd, logic wr, logic [31:0] addr, logic [31:0] wdata,
		logic [3:0] be);
		rowT r;
		r = prog.pop_back();
		r.memRead = rd;
		r.memWrite = wr;
		r.addr = addr;
		r.wdata = wdata;
		r.byteEn = be;
		prog.push_back(r);
	endtask

	// Load result by RV32I rules from the model RAM
	function automatic logic [31:0] loadValue(logic [31:0] addr, logic [2:0] f3);
		logic [31:0] lane;
		lane = ram[addr[7:2]] >> (8 * addr[1:0]);
		case (f3)
			3'b000:  return {{24{lane[7]}}, lane[7:0]};
			3'b001:  return {{16{lane[15]}}, lane[15:0]};
			3'b100:  return {24'b0, lane[7:0]};
			3'b101:  return {16'b0, lane[15:0]};
			default: return lane;
		endcase
	endfunction

	////////////////////////////////////////////////////////////
	// Checks
	////////////////////////////////////////////////////////////
	task automatic reportFail(string what);
		$display("%s", what);
		$display("Test FAILED");
		$fatal(1);
	endtask

	task automatic compareHex(string name, logic [31:0] act, logic [31:0] exp);
		if (act !== exp)
			reportFail($sformatf("** Error: %s = %h, expected %h", name, act, exp));
	endtask

	task automatic checkRetire(retireT act, retireT exp);
		compareHex("retire.valid", 32'(act.valid), 32'(exp.valid));
		compareHex("retire.pc", act.pc, exp.pc);
		compareHex("retire.instr", act.instr, exp.instr);
		compareHex("retire.rdWrite", 32'(act.rdWrite), 32'(exp.rdWrite));
		if (exp.rdWrite) begin // Data only matters when written
			compareHex("retire.rd", 32'(act.rd), 32'(exp.rd));
			compareHex("retire.rdData", act.rdData, exp.rdData);
		end
	endtask

	task automatic checkDmem(dmemReqT act, dmemReqT exp);
		compareHex("dmemReq.read", 32'(act.read), 32'(exp.read));
		compareHex("dmemReq.write", 32'(act.write), 32'(exp.write));
		compareHex("dmemReq.byteEn", 32'(act.byteEn), 32'(exp.byteEn));
		if (exp.read || exp.write)
			compareHex("dmemReq.addr", act.addr, exp.addr);
		if (exp.write)
			compareHex("dmemReq.wdata", act.wdata, exp.wdata);
	endtask

	////////////////////////////////////////////////////////////
	// Program where x3 = -5 and x4 = 7 drive most checks
	////////////////////////////////////////////////////////////
	task automatic buildProgram();
		addRow(0, encU(20'h12345, 1, 7'b0110111), 1, 1, 32'h12345000);
		addRow(4, encU(20'h00001, 2, 7'b0010111), 1, 2, BASE + 32'h1004);
		addRow(8, encI(-5, 0, 3'b000, 3, 7'b0010011), 1, 3, 32'hFFFFFFFB);
		addRow(12, encI(7, 0, 3'b000, 4, 7'b0010011), 1, 4, 32'h7);
		addRow(16, encR(7'h00, 4, 3, 3'b000, 5), 1, 5, 32'h2);
		addRow(20, encR(7'h20, 4, 3, 3'b000, 6), 1, 6, 32'hFFFFFFF4);
		addRow(24, encR(7'h00, 4, 4, 3'b001, 7), 1, 7, 32'h380);
		addRow(28, encR(7'h00, 4, 3, 3'b010, 8), 1, 8, 32'h1);      // Signed -5 < 7
		addRow(32, encR(7'h00, 4, 3, 3'b011, 9), 1, 9, 32'h0);      // Unsigned big
		addRow(36, encR(7'h00, 4, 3, 3'b100, 10), 1, 10, 32'hFFFFFFFC);
		addRow(40, encR(7'h00, 4, 3, 3'b101, 11), 1, 11, 32'h01FFFFFF);
		addRow(44, encR(7'h20, 4, 3, 3'b101, 12), 1, 12, 32'hFFFFFFFF);
		addRow(48, encR(7'h00, 4, 3, 3'b110, 13), 1, 13, 32'hFFFFFFFF);
		addRow(52, encR(7'h00, 4, 3, 3'b111, 14), 1, 14, 32'h3);
		addRow(56, encI(12'h0F0, 4, 3'b100, 15, 7'b0010011), 1, 15, 32'hF7);
		addRow(60, encI(12'h401, 3, 3'b101, 16, 7'b0010011), 1, 16, 32'hFFFFFFFD);
		addRow(64, encI(28, 3, 3'b101, 17, 7'b0010011), 1, 17, 32'hF);
		addRow(68, encI(-1, 4, 3'b011, 18, 7'b0010011), 1, 18, 32'h1);
		addRow(72, encI(5, 4, 3'b000, 0, 7'b0010011), 1, 0, 32'hC); // Write to x0
		addRow(76, encR(7'h00, 4, 0, 3'b000, 19), 1, 19, 32'h7);    // x0 still zero
		addRow(80, encI(-4, 3, 3'b010, 20, 7'b0010011), 1, 20, 32'h1);
		addRow(84, encI(12'h100, 4, 3'b110, 21, 7'b0010011), 1, 21, 32'h107);
		addRow(88, encI(12'h0F0, 3, 3'b111, 22, 7'b0010011), 1, 22, 32'hF0);
		addRow(92, encI(4, 4, 3'b001, 23, 7'b0010011), 1, 23, 32'h70);
		// Stores
		addRow(96, encS(12'h40, 1, 0, 3'b010), 0, 0, 0);
		addMem(0, 1, 32'h40, 32'h12345000, 4'b1111);
		addRow(100, encS(12'h46, 4, 0, 3'b001), 0, 0, 0);
		addMem(0, 1, 32'h46, 32'h00070000, 4'b1100);
		addRow(104, encS(12'h49, 3, 0, 3'b000), 0, 0, 0);
		addMem(0, 1, 32'h49, 32'hFFFFFB00, 4'b0010);
		// Loads with data filled in at check time
		addRow(108, encI(12'h40, 0, 3'b010, 24, 7'b0000011), 1, 24, 0);
		addMem(1, 0, 32'h40, 0, 4'b1111);
		addRow(112, encI(12'h13, 0, 3'b000, 25, 7'b0000011), 1, 25, 0);
		addMem(1, 0, 32'h13, 0, 4'b1000);
		addRow(116, encI(12'h11, 0, 3'b100, 26, 7'b0000011), 1, 26, 0);
		addMem(1, 0, 32'h11, 0, 4'b0010);
		addRow(120, encI(12'h22, 0, 3'b001, 27, 7'b0000011), 1, 27, 0);
		addMem(1, 0, 32'h22, 0, 4'b1100);
		addRow(124, encI(12'h2A, 0, 3'b101, 28, 7'b0000011), 1, 28, 0);
		addMem(1, 0, 32'h2A, 0, 4'b1100);
		// Branches that skip one word when taken
		addRow(128, encB(8, 4, 4, 3'b000), 0, 0, 0);
		addRow(136, encB(8, 4, 4, 3'b001), 0, 0, 0);
		addRow(140, encB(8, 3, 4, 3'b100), 0, 0, 0);
		addRow(148, encB(8, 3, 4, 3'b101), 0, 0, 0);
		addRow(152, encB(8, 3, 4, 3'b110), 0, 0, 0);
		addRow(156, encB(8, 3, 4, 3'b111), 0, 0, 0);
		addRow(164, encB(8, 3, 4, 3'b000), 0, 0, 0);
		addRow(168, encB(8, 3, 4, 3'b001), 0, 0, 0);
		addRow(176, encB(8, 4, 3, 3'b100), 0, 0, 0);
		addRow(180, encB(8, 4, 3, 3'b101), 0, 0, 0);
		addRow(188, encB(8, 4, 3, 3'b110), 0, 0, 0);
		addRow(196, encB(8, 4, 3, 3'b111), 0, 0, 0);
		// Jumps
		addRow(200, encJ(12, 30), 1, 30, BASE + 32'd204);
		addRow(212, encU(20'h0, 31, 7'b0010111), 1, 31, BASE + 32'd212);
		addRow(216, encI(29, 31, 3'b000, 5, 7'b1100111), 1, 5, BASE + 32'd220); // Odd target
		addRow(240, encI(0, 30, 3'b000, 20, 7'b0010011), 1, 20, BASE + 32'd204);
	endtask

	////////////////////////////////////////////////////////////
	// Main sequence
	////////////////////////////////////////////////////////////
	initial begin
		retireT  expRet;
		dmemReqT expMem;
		rowT     r;
		clk = 1'b0;
		arstN = 1'b0;
		void'($urandom(3));
		for (int i = 0; i < 64; i++) begin
			rom[i] = encI(i, 0, 3'b000, 0, 7'b0010011); // ADDI x0 tagged with word index
			ram[i] = $urandom;
		end
		// Top lane bits set so sign and zero extension differ
		ram[4][31] = 1'b1;
		ram[4][15] = 1'b1;
		ram[8][31] = 1'b1;
		ram[10][31] = 1'b1;
		buildProgram();
		foreach (prog[i])
			rom[prog[i].pc[7:2]] = prog[i].instr;

		fork
			begin
				#((prog.size() + 10) * CLK_PERIOD);
				reportFail("Watchdog expired before the program finished");
			end
		join_none

		repeat (4) @(negedge clk);
		#1;
		// Idle outputs during reset
		compareHex("retire.valid", 32'(retire.valid), 32'h0);
		compareHex("retire.pc", retire.pc, BASE);
		compareHex("dmemReq.read", 32'(dmemReq.read), 32'h0);
		compareHex("dmemReq.write", 32'(dmemReq.write), 32'h0);
		@(negedge clk);
		arstN = 1'b1;

		foreach (prog[i]) begin
			if (i > 0)
				@(negedge clk);
			#1;
			r = prog[i];
			expRet = '0;
			expRet.valid = 1'b1;
			expRet.pc = r.pc;
			expRet.instr = r.instr;
			expRet.rdWrite = r.rdWrite;
			expRet.rd = r.rd;
			expRet.rdData = r.memRead ? loadValue(r.addr, r.instr[14:12]) : r.rdData;
			expMem = '0;
			expMem.addr = {r.addr[31:2], 2'b00};
			expMem.wdata = r.wdata;
			expMem.byteEn = r.byteEn;
			expMem.read = r.memRead;
			expMem.write = r.memWrite;
			compareHex("imemAddr", imemAddr, r.pc);
			checkRetire(retire, expRet);
			checkDmem(dmemReq, expMem);
		end

		$display("Test OK");
		$finish;
	end

endmodule
